/* Makefile */
VERILATOR ?= verilator
TOP       ?= weight_load_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/glb_sram.sv */
`timescale 1ns/1ps
module glb_sram
    import wl_pkg::*;
#(
    parameter int GLB_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  glb_wr_t     wr,
    input  glb_rd_req_t rd_req,
    output glb_word_u   rd_data
);

    localparam int AW = (GLB_WORDS > 1) ? $clog2(GLB_WORDS) : 1;

    logic [31:0]   mem [GLB_WORDS];  // word organized storage
    logic [31:0]   wr_word;          // host index wrapped to the depth
    logic [31:0]   rd_word;          // byte address to word index, wrapped
    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd_idx;

    assign wr_word = wr.idx % 32'(GLB_WORDS);
    assign rd_word = (rd_req.addr >> 2) % 32'(GLB_WORDS);
    assign wr_idx  = wr_word[AW-1:0];
    assign rd_idx  = rd_word[AW-1:0];

    // host preload port
    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr_idx] <= wr.data;
    end

    // registered read, data one cycle after en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_data.word <= '0;
        else if (rd_req.en)
            rd_data.word <= mem[rd_idx];  // old data if written in the same cycle
    end

endmodule

/* design/pe_weight_array.sv */
`timescale 1ns/1ps
module pe_weight_array
    import wl_pkg::*;
#(
    parameter int ARRAY_DIM = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  wl_load_t   load,
    input  glb_word_u  glb_data,
    input  logic [7:0] rd_row,
    input  logic [7:0] rd_col,
    output logic [7:0] rd_weight
);

    localparam int N = ARRAY_DIM * ARRAY_DIM;

    logic [N-1:0][7:0] cells;      // flat view, index row*ARRAY_DIM+col
    logic [7:0]        lane_byte;  // byte picked from the incoming word

    assign lane_byte = glb_data.bytes[load.byte_sel];

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            logic       cell_en;  // decoded from the row/col index
            logic [7:0] w_q;      // pe weight register

            assign cell_en = load.en && (load.row == 8'(r)) && (load.col == 8'(c));

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                    w_q <= '0;
                else if (cell_en)
                    w_q <= lane_byte;
            end

            assign cells[r*ARRAY_DIM+c] = w_q;
        end
    end

    // readback mux, index outside the array reads 0
    always_comb begin
        rd_weight = '0;
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int j = 0; j < ARRAY_DIM; j++) begin
                if (rd_row == 8'(i) && rd_col == 8'(j))
                    rd_weight = cells[i*ARRAY_DIM+j];
            end
        end
    end

endmodule

/* design/weight_load_controller.sv */
`timescale 1ns/1ps
module weight_load_controller
    import wl_pkg::*;
#(
    parameter int ARRAY_DIM = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  layer_type_e layer,
    input  logic [31:0] base,
    output glb_rd_req_t rd_req,
    output wl_load_t    load,
    output logic        busy,
    output logic        done_pulse,
    output logic        err_pulse
);

    localparam logic [7:0] LAST_IDX = 8'(ARRAY_DIM - 1);

    logic        busy_q;     // read stage active
    logic        linear_q;   // layer latched at start
    logic [7:0]  minor_q;    // fast digit of the byte counter
    logic [7:0]  major_q;    // slow digit of the byte counter
    logic [31:0] addr_q;     // glb byte address of the current read
    logic        accept;     // start taken this cycle
    logic        supported;
    logic        last_rd;    // read n-1 goes out this cycle
    logic        last_ld_q;  // load n-1 happens this cycle
    logic        ld_en_q;
    logic [7:0]  ld_row_q;
    logic [7:0]  ld_col_q;
    logic [1:0]  ld_sel_q;

    assign supported = (layer == LT_POINTWISE) || (layer == LT_LINEAR);
    assign accept    = start && !busy_q;  // start while busy is dropped
    assign last_rd   = busy_q && (minor_q == LAST_IDX) && (major_q == LAST_IDX);

    // read stage control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            linear_q  <= 1'b0;
            minor_q   <= '0;
            major_q   <= '0;
            err_pulse <= 1'b0;
        end else begin
            err_pulse <= accept && !supported;  // depthwise or standard
            if (accept && supported) begin
                busy_q   <= 1'b1;
                linear_q <= (layer == LT_LINEAR);
                minor_q  <= '0;
                major_q  <= '0;
            end else if (busy_q) begin
                if (last_rd)
                    busy_q <= 1'b0;
                if (minor_q == LAST_IDX) begin
                    minor_q <= '0;
                    major_q <= major_q + 8'd1;
                end else begin
                    minor_q <= minor_q + 8'd1;
                end
            end
        end
    end

    // byte address walks up from base, one byte per cycle
    always_ff @(posedge clk) begin
        if (accept)
            addr_q <= base;
        else if (busy_q)
            addr_q <= addr_q + 32'd1;
    end

    assign rd_req.en   = busy_q;
    assign rd_req.addr = addr_q;
    assign busy        = busy_q;

    // load stage, one cycle behind the read to meet the glb data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_en_q    <= 1'b0;
            last_ld_q  <= 1'b0;
            done_pulse <= 1'b0;
        end else begin
            ld_en_q    <= busy_q;
            last_ld_q  <= last_rd;
            done_pulse <= last_ld_q;  // cycle after the last load
        end
    end

    always_ff @(posedge clk) begin
        if (busy_q) begin
            ld_sel_q <= addr_q[1:0];                    // byte lane of this address
            ld_row_q <= linear_q ? minor_q : major_q;   // linear is transposed
            ld_col_q <= linear_q ? major_q : minor_q;
        end
    end

    assign load.en       = ld_en_q;
    assign load.row      = ld_row_q;
    assign load.col      = ld_col_q;
    assign load.byte_sel = ld_sel_q;

endmodule

/* design/weight_load_top.sv */
`timescale 1ns/1ps
module weight_load_top
    import wl_pkg::*;
#(
    parameter int ARRAY_DIM = 8,
    parameter int GLB_WORDS = 64
) (
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb,
    output apb_rsp_t apb_rsp,
    input  glb_wr_t  glb_wr
);

    logic        start;       // from regs, one cycle
    layer_type_e layer;
    logic [31:0] base;
    logic        busy;
    logic        done_pulse;
    logic        err_pulse;
    glb_rd_req_t rd_req;      // controller to glb
    glb_word_u   rd_data;     // glb to pe array
    wl_load_t    load;        // controller to pe array
    logic [7:0]  rd_row;
    logic [7:0]  rd_col;
    logic [7:0]  rd_weight;

    wl_cfg_regs #(
        .ARRAY_DIM (ARRAY_DIM)
    ) regs_i (
        .clk, .rst_n, .apb, .apb_rsp,
        .busy, .done_pulse, .err_pulse, .rd_weight,
        .start, .layer, .base, .rd_row, .rd_col
    );

    weight_load_controller #(
        .ARRAY_DIM (ARRAY_DIM)
    ) ctrl_i (
        .clk, .rst_n, .start, .layer, .base,
        .rd_req, .load, .busy, .done_pulse, .err_pulse
    );

    glb_sram #(
        .GLB_WORDS (GLB_WORDS)
    ) glb_i (
        .clk,
        .rst_n,
        .wr      (glb_wr),
        .rd_req,
        .rd_data
    );

    pe_weight_array #(
        .ARRAY_DIM (ARRAY_DIM)
    ) pe_i (
        .clk,
        .rst_n,
        .load,
        .glb_data (rd_data),
        .rd_row,
        .rd_col,
        .rd_weight
    );

endmodule

/* design/wl_cfg_regs.sv */
`timescale 1ns/1ps
module wl_cfg_regs
    import wl_pkg::*;
#(
    parameter int ARRAY_DIM = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  apb_req_t    apb,
    output apb_rsp_t    apb_rsp,
    input  logic        busy,
    input  logic        done_pulse,
    input  logic        err_pulse,
    input  logic [7:0]  rd_weight,
    output logic        start,
    output layer_type_e layer,
    output logic [31:0] base,
    output logic [7:0]  rd_row,
    output logic [7:0]  rd_col
);

    logic        access;    // apb access phase
    logic        wr_en;
    logic        mapped;    // offset hits a register
    logic        ro_write;  // write to a read-only offset
    logic        done_q;    // sticky done
    logic        err_q;     // sticky err
    logic [31:0] rdata;

    assign access   = apb.psel && apb.penable;
    assign ro_write = apb.pwrite && (apb.paddr == REG_WDATA || apb.paddr == REG_STATUS);
    assign wr_en    = access && apb.pwrite && mapped && !ro_write;

    // read mux and address decode
    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (apb.paddr)
            REG_CTRL:   rdata = {8'h00, 16'(ARRAY_DIM), 8'h00};  // start reads 0, side in 23:8
            REG_STATUS: rdata = {29'd0, err_q, done_q, busy};
            REG_LAYER:  rdata = {30'd0, layer};
            REG_BASE:   rdata = base;
            REG_WSEL:   rdata = {16'd0, rd_row, rd_col};
            REG_WDATA:  rdata = {24'd0, rd_weight};              // straight from pe array
            default:    mapped = 1'b0;
        endcase
    end

    assign apb_rsp.pready  = 1'b1;  // no wait states
    assign apb_rsp.pslverr = access && (!mapped || ro_write);
    assign apb_rsp.prdata  = rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start  <= 1'b0;
            layer  <= LT_STANDARD;
            base   <= '0;
            rd_row <= '0;
            rd_col <= '0;
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            start <= wr_en && (apb.paddr == REG_CTRL) && apb.pwdata[0];  // one cycle pulse
            if (wr_en && !busy && apb.paddr == REG_LAYER)
                layer <= layer_type_e'(apb.pwdata[1:0]);  // config frozen while busy
            if (wr_en && !busy && apb.paddr == REG_BASE)
                base <= apb.pwdata;
            if (wr_en && apb.paddr == REG_WSEL) begin
                rd_row <= apb.pwdata[15:8];
                rd_col <= apb.pwdata[7:0];
            end
            // sticky status, a new start clears it
            if (done_pulse)
                done_q <= 1'b1;
            else if (start)
                done_q <= 1'b0;
            if (err_pulse)
                err_q <= 1'b1;
            else if (start)
                err_q <= 1'b0;
        end
    end

endmodule

/* design/wl_pkg.sv */
package wl_pkg;

    // layer encodings as seen in REG_LAYER
    typedef enum logic [1:0] {
        LT_STANDARD  = 2'd0,  // not supported, raises err
        LT_DEPTHWISE = 2'd1,  // not supported, raises err
        LT_LINEAR    = 2'd2,  // column-major fill
        LT_POINTWISE = 2'd3   // row-major fill
    } layer_type_e;

    // apb register offsets
    localparam logic [7:0] REG_CTRL   = 8'h00;  // bit 0 start, write one
    localparam logic [7:0] REG_STATUS = 8'h04;  // busy, done, err
    localparam logic [7:0] REG_LAYER  = 8'h08;  // layer type
    localparam logic [7:0] REG_BASE   = 8'h0C;  // weight byte address in glb
    localparam logic [7:0] REG_WSEL   = 8'h10;  // readback row 15:8, col 7:0
    localparam logic [7:0] REG_WDATA  = 8'h14;  // selected weight, read only

    // one glb word, read whole or as byte lanes
    typedef union packed {
        logic [31:0]      word;   // raw word
        logic [3:0][7:0]  bytes;  // lane 0 is the low byte
    } glb_word_u;

    typedef struct packed {
        logic        en;    // read strobe
        logic [31:0] addr;  // byte address
    } glb_rd_req_t;

    typedef struct packed {
        logic        en;    // host write strobe
        logic [31:0] idx;   // word index
        logic [31:0] data;  // word to store
    } glb_wr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic       en;        // write one pe cell this cycle
        logic [7:0] row;
        logic [7:0] col;
        logic [1:0] byte_sel;  // lane of the returning glb word
    } wl_load_t;

endpackage

/* files.f */
design/wl_pkg.sv
design/wl_cfg_regs.sv
design/weight_load_controller.sv
design/glb_sram.sv
design/pe_weight_array.sv
design/weight_load_top.sv
verification/tb_clk_gen.sv
verification/weight_load_checker.sv
verification/weight_load_tb.sv

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps
module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;                          // asserted from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                        // release away from the active edge
        rst_n = 1'b1;
    end

endmodule

/* verification/weight_load_checker.sv */
`timescale 1ns/1ps
module weight_load_checker
    import wl_pkg::*;
#(
    parameter int ARRAY_DIM = 8,
    parameter int GLB_WORDS = 64
) (
    input logic     clk,
    input logic     rst_n,
    input apb_req_t apb,
    input apb_rsp_t apb_rsp,
    input glb_wr_t  glb_wr
);

    localparam int N       = ARRAY_DIM * ARRAY_DIM;
    localparam int AGE_CAP = N + 8;           // status is settled well before this

    int          errors = 0;
    string       test_name = "none";
    logic [31:0] mirror [GLB_WORDS];          // copy of the host preload
    logic [7:0]  w_exp [N];                   // predicted weights by row*ARRAY_DIM+col
    logic [31:0] base_exp = '0;
    layer_type_e layer_exp = LT_STANDARD;     // layer register after reset
    logic [7:0]  sel_row = '0;
    logic [7:0]  sel_col = '0;
    logic        seen_start = 1'b0;
    logic        pend_err = 1'b0;             // next start is an unsupported layer
    logic        load_err = 1'b0;             // last start was an unsupported layer
    logic        prev_done = 1'b0;            // sticky bits as they were at the last start
    logic        prev_err = 1'b0;
    int          age = 0;                     // cycles since the start write

    initial begin
        for (int i = 0; i < N; i++)
            w_exp[i] = 8'h00;                 // weights clear after reset
    end

    task automatic mismatch(input string what, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
        errors++;
        $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    endtask

    // predicts the array contents of a new test from the load rules
    task automatic set_test(input string name, input layer_type_e layer,
                            input logic [31:0] base, input logic do_load, input logic err_exp);
        logic [31:0] a;
        int          widx;
        int          row;
        int          col;
        test_name = name;
        if (do_load) begin
            pend_err = err_exp;
            for (int n = 0; n < N && !err_exp; n++) begin
                a    = base + 32'(n);
                widx = int'((a >> 2) % 32'(GLB_WORDS));    // word index wraps
                row  = (layer == LT_LINEAR) ? n % ARRAY_DIM : n / ARRAY_DIM;
                col  = (layer == LT_LINEAR) ? n / ARRAY_DIM : n % ARRAY_DIM;
                w_exp[row*ARRAY_DIM+col] = mirror[widx][8*int'(a[1:0]) +: 8];  // byte lane
            end
        end
    endtask

    function automatic logic [31:0] status_exp();
        logic busy_e;
        logic done_e;
        logic err_e;
        busy_e = 1'b0;
        done_e = prev_done;
        err_e  = prev_err;
        if (seen_start && age > 0) begin      // start pulse has cleared the sticky bits
            busy_e = !load_err && age <= N;
            done_e = !load_err && age >= N + 3;  // done pulse at N+2 after start and sticky
            err_e  = load_err && age >= 2;
        end
        return {29'd0, err_e, done_e, busy_e};
    endfunction

    function automatic logic [7:0] weight_exp();
        if (int'(sel_row) < ARRAY_DIM && int'(sel_col) < ARRAY_DIM)
            return w_exp[int'(sel_row)*ARRAY_DIM+int'(sel_col)];
        return 8'h00;                         // outside the array
    endfunction

    task automatic check_access();
        logic [31:0] st;
        logic        mapped;
        logic        err_e;
        st     = status_exp();
        mapped = apb.paddr inside {REG_CTRL, REG_STATUS, REG_LAYER, REG_BASE, REG_WSEL, REG_WDATA};
        err_e  = !mapped || (apb.pwrite && (apb.paddr == REG_STATUS || apb.paddr == REG_WDATA));
        if (apb_rsp.pslverr !== err_e)
            mismatch("pslverr", 32'(err_e), 32'(apb_rsp.pslverr));
        if (apb_rsp.pready !== 1'b1)
            mismatch("pready", 32'd1, 32'(apb_rsp.pready));
        if (!apb.pwrite) begin
            if (apb.paddr == REG_STATUS && apb_rsp.prdata !== st)
                mismatch("status", st, apb_rsp.prdata);
            if (apb.paddr == REG_WDATA && apb_rsp.prdata !== {24'd0, weight_exp()})
                mismatch($sformatf("weight[%0d][%0d]", sel_row, sel_col),
                         {24'd0, weight_exp()}, apb_rsp.prdata);
            if (apb.paddr == REG_BASE && apb_rsp.prdata !== base_exp)
                mismatch("base", base_exp, apb_rsp.prdata);
            if (apb.paddr == REG_LAYER && apb_rsp.prdata !== 32'(layer_exp))
                mismatch("layer", 32'(layer_exp), apb_rsp.prdata);
        end else if (!err_e) begin
            if (apb.paddr == REG_BASE && !st[0])
                base_exp = apb.pwdata;        // dropped while busy
            if (apb.paddr == REG_LAYER && !st[0])
                layer_exp = layer_type_e'(apb.pwdata[1:0]);  // held while busy
            if (apb.paddr == REG_WSEL) begin
                sel_row = apb.pwdata[15:8];
                sel_col = apb.pwdata[7:0];
            end
            if (apb.paddr == REG_CTRL && apb.pwdata[0]) begin
                prev_done  = st[1];
                prev_err   = st[2];
                load_err   = pend_err;
                seen_start = 1'b1;
                age        = -1;              // zero once this edge is counted
            end
        end
    endtask

    always @(posedge clk) begin
        if (glb_wr.en)
            mirror[int'(glb_wr.idx % 32'(GLB_WORDS))] = glb_wr.data;
        if (rst_n && apb.psel && apb.penable)
            check_access();
        if (age < AGE_CAP)
            age++;
    end

endmodule

/* verification/weight_load_tb.sv */
`timescale 1ns/1ps
module weight_load_tb
    import wl_pkg::*;
();

    localparam int ARRAY_DIM   = 8;
    localparam int GLB_WORDS   = 64;
    localparam int N           = ARRAY_DIM * ARRAY_DIM;
    localparam int NUM_TESTS   = 6;
    localparam int ACCESS_CYC  = 3;                            // setup, access, idle
    localparam int TEST_CYC    = N + 2 * N * ACCESS_CYC + 64;  // load, full readback, margin
    localparam int PRELOAD_CYC = GLB_WORDS + 32;               // reset and glb preload
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYC + PRELOAD_CYC;
    localparam int POLL_LIMIT  = N;

    typedef struct packed {
        layer_type_e layer;
        logic [31:0] base;
        logic        do_load;   // program and start a load
        logic        err_exp;   // unsupported layer
        logic        base_wr;   // rewrite BASE while busy
        logic [7:0]  n_rb;      // cells read back, row major from 0,0
    } test_t;

    logic     clk;
    logic     rst_n;
    apb_req_t apb;
    apb_rsp_t apb_rsp;
    glb_wr_t  glb_wr;
    int       seed = 32'hbb0ffee2;
    int       tb_errors = 0;
    test_t    tests [NUM_TESTS];
    string    names [NUM_TESTS];

    tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) clk_gen_i (.clk, .rst_n);

    weight_load_top #(
        .ARRAY_DIM (ARRAY_DIM),
        .GLB_WORDS (GLB_WORDS)
    ) dut_i (.clk, .rst_n, .apb, .apb_rsp, .glb_wr);

    weight_load_checker #(
        .ARRAY_DIM (ARRAY_DIM),
        .GLB_WORDS (GLB_WORDS)
    ) chk_i (.clk, .rst_n, .apb, .apb_rsp, .glb_wr);

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] rdata);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        @(negedge clk);
        apb.penable = 1'b1;
        @(negedge clk);
        rdata       = apb_rsp.prdata;  // state just after the access edge
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(negedge clk);
        apb.penable = 1'b1;
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic preload_glb();
        for (int i = 0; i < GLB_WORDS; i++) begin
            @(negedge clk);
            glb_wr.en   = 1'b1;
            glb_wr.idx  = 32'(i);
            glb_wr.data = $random(seed);
        end
        @(negedge clk);
        glb_wr.en = 1'b0;
    endtask

    // poll until done or err shows up
    task automatic wait_load();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (st[2:1] == 2'b00 && polls < POLL_LIMIT) begin
            reg_read(REG_STATUS, st);
            polls++;
        end
        if (st[2:1] == 2'b00) begin
            tb_errors++;
            $display("load reported neither done nor err after %0d status reads", polls);
        end
    endtask

    task automatic read_back(input int count);
        logic [31:0] rd;
        for (int i = 0; i < count; i++) begin
            reg_write(REG_WSEL, {16'd0, 8'(i / ARRAY_DIM), 8'(i % ARRAY_DIM)});
            reg_read(REG_WDATA, rd);
        end
    endtask

    task automatic run_test(input int t);
        logic [31:0] rd;
        chk_i.set_test(names[t], tests[t].layer, tests[t].base, tests[t].do_load,
                       tests[t].err_exp);
        if (tests[t].do_load) begin
            reg_write(REG_LAYER, 32'(tests[t].layer));
            reg_write(REG_BASE, tests[t].base);
            reg_write(REG_CTRL, 32'h1);
            if (tests[t].base_wr)
                reg_write(REG_BASE, ~tests[t].base);  // lands mid load
            wait_load();
        end else begin
            reg_read(REG_STATUS, rd);
        end
        read_back(int'(tests[t].n_rb));
        if (tests[t].base_wr)
            reg_read(REG_BASE, rd);
    endtask

    task automatic apb_error_checks();
        logic [31:0] rd;
        chk_i.set_test("apb_errors", LT_STANDARD, 32'h0, 1'b0, 1'b0);
        reg_read(8'h18, rd);                  // past the map
        reg_read(8'h02, rd);                  // misaligned
        reg_write(REG_WDATA, 32'h0000_00ff);
        reg_write(REG_STATUS, 32'h0000_0007);
        reg_read(REG_LAYER, rd);
        reg_write(REG_WSEL, 32'h0000_0800);   // row 8 is outside the array
        reg_read(REG_WDATA, rd);
    endtask

    initial begin
        apb    = '0;
        glb_wr = '0;
        names[0] = "reset_state";
        tests[0] = '{LT_STANDARD,  32'h0000_0000, 1'b0, 1'b0, 1'b0, 8'd8};
        names[1] = "pointwise_aligned";
        tests[1] = '{LT_POINTWISE, 32'h0000_0010, 1'b1, 1'b0, 1'b0, 8'd64};
        names[2] = "linear_unaligned";
        tests[2] = '{LT_LINEAR,    32'h0000_000D, 1'b1, 1'b0, 1'b0, 8'd64};
        names[3] = "depthwise_rejected";
        tests[3] = '{LT_DEPTHWISE, 32'h0000_0040, 1'b1, 1'b1, 1'b0, 8'd64};
        names[4] = "standard_rejected";
        tests[4] = '{LT_STANDARD,  32'h0000_0020, 1'b1, 1'b1, 1'b0, 8'd8};
        names[5] = "wrap_busy_base";
        tests[5] = '{LT_POINTWISE, 32'h0000_01F5, 1'b1, 1'b0, 1'b1, 8'd64};
        wait (rst_n === 1'b1);
        preload_glb();
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        apb_error_checks();
        @(negedge clk);
        $display("errors: checker %0d, testbench %0d", chk_i.errors, tb_errors);
        if (chk_i.errors == 0 && tb_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", cycles);
        $display("Checks failed");
        $finish;
    end

endmodule
